//--- Bender.yml
package:
  name: lsu_sys

sources:
  - lsu_pkg.sv
  - lsu.sv
  - lsu_xbar.sv
  - sram_axil.sv
  - clint_axil.sv
  - lsu_sys.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_lsu_sys.sv

//--- clint_axil.sv
`timescale 1ns/1ns
`default_nettype none

module clint_axil
    import lsu_pkg::*;
(
    input  wire            clk,
    input  wire            rst_n,
    input  wire axil_req_t bus_req,
    output axil_rsp_t      bus_rsp
);

    logic [63:0] mtime_q;
    logic [31:0] hi_snap_q;
    logic [31:0] r_data_q;
    logic        r_valid_q;
    logic        aw_got_q;
    logic        w_got_q;
    logic        b_valid_q;
    logic        ar_hs, aw_hs, w_hs, wr_fire;
    logic [13:0] word_off;

    always_comb begin
        bus_rsp          = '0;
        bus_rsp.aw_ready = !aw_got_q && !b_valid_q;
        bus_rsp.w_ready  = !w_got_q && !b_valid_q;
        bus_rsp.b_valid  = b_valid_q;
        bus_rsp.b_resp   = resp_slverr;     // mtime is read only
        bus_rsp.ar_ready = !r_valid_q;
        bus_rsp.r_valid  = r_valid_q;
        bus_rsp.r_data   = r_data_q;
        bus_rsp.r_resp   = resp_okay;
    end

    assign ar_hs    = bus_req.ar_valid && bus_rsp.ar_ready;
    assign aw_hs    = bus_req.aw_valid && bus_rsp.aw_ready;
    assign w_hs     = bus_req.w_valid && bus_rsp.w_ready;
    assign wr_fire  = (aw_got_q || aw_hs) && (w_got_q || w_hs);
    assign word_off = bus_req.ar_addr[15:2];    // window is 64 KiB aligned

    always_ff @(posedge clk) begin
        if (ar_hs) begin
            case (word_off)
                14'd0: begin
                    r_data_q  <= mtime_q[31:0];
                    hi_snap_q <= mtime_q[63:32];    // keeps lo/hi pair coherent
                end
                14'd1:   r_data_q <= hi_snap_q;
                default: r_data_q <= '0;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mtime_q   <= '0;
            r_valid_q <= 1'b0;
            aw_got_q  <= 1'b0;
            w_got_q   <= 1'b0;
            b_valid_q <= 1'b0;
        end else begin
            mtime_q <= mtime_q + 64'd1;
            if (ar_hs) r_valid_q <= 1'b1;
            else if (bus_req.r_ready) r_valid_q <= 1'b0;
            if (wr_fire) begin
                aw_got_q  <= 1'b0;
                w_got_q   <= 1'b0;
                b_valid_q <= 1'b1;
            end else begin
                if (aw_hs) aw_got_q <= 1'b1;
                if (w_hs) w_got_q <= 1'b1;
                if (bus_req.b_ready) b_valid_q <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

//--- lsu.sv
`timescale 1ns/1ns
`default_nettype none

module lsu
    import lsu_pkg::*;
(
    input  wire            clk,
    input  wire            rst_n,
    input  wire            req_valid,
    output logic           req_ready,
    input  wire lsu_req_t  req,
    output logic           rsp_valid,
    input  wire            rsp_ready,
    output lsu_rsp_t       rsp,
    output axil_req_t      bus_req,
    input  wire axil_rsp_t bus_rsp
);

    typedef enum logic [1:0] {
        st_idle,
        st_addr,
        st_wait,
        st_resp
    } state_e;

    state_e      state_q;
    lsu_req_t    req_q;
    logic        ar_valid_q;
    logic        aw_valid_q;
    logic        w_valid_q;
    logic        err_q;
    logic [31:0] rword_q;
    logic        req_hs;
    logic        r_hs;
    logic        b_hs;
    logic        bad_align;
    logic        addr_pend;
    logic [3:0]  strb;
    logic [4:0]  shamt;
    logic [31:0] rshift;

    assign req_ready = (state_q == st_idle);
    assign rsp_valid = (state_q == st_resp);
    assign req_hs    = req_valid && req_ready;
    assign r_hs      = bus_rsp.r_valid && bus_req.r_ready;
    assign b_hs      = bus_rsp.b_valid && bus_req.b_ready;

    // any valid still waiting after this cycle
    assign addr_pend = (ar_valid_q && !bus_rsp.ar_ready) ||
                       (aw_valid_q && !bus_rsp.aw_ready) ||
                       (w_valid_q && !bus_rsp.w_ready);

    always_comb begin
        case (req.size)
            size_byte: bad_align = 1'b0;
            size_half: bad_align = req.addr[0];
            size_word: bad_align = |req.addr[1:0];
            default:   bad_align = 1'b1;    // no such width
        endcase
    end

    always_comb begin
        case (req_q.size)
            size_byte: strb = 4'b0001 << req_q.addr[1:0];
            size_half: strb = req_q.addr[1] ? 4'b1100 : 4'b0011;
            default:   strb = 4'b1111;
        endcase
    end

    assign shamt = {req_q.addr[1:0], 3'b000};

    always_comb begin
        bus_req          = '0;          // prot stays unprivileged data
        bus_req.aw_valid = aw_valid_q;
        bus_req.aw_addr  = req_q.addr;
        bus_req.w_valid  = w_valid_q;
        bus_req.w_data   = req_q.wdata << shamt;
        bus_req.w_strb   = strb;
        bus_req.b_ready  = (state_q == st_wait);
        bus_req.ar_valid = ar_valid_q;
        bus_req.ar_addr  = req_q.addr;
        bus_req.r_ready  = (state_q == st_wait);
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q    <= st_idle;
            ar_valid_q <= 1'b0;
            aw_valid_q <= 1'b0;
            w_valid_q  <= 1'b0;
            err_q      <= 1'b0;
        end else begin
            if (bus_rsp.ar_ready) ar_valid_q <= 1'b0;
            if (bus_rsp.aw_ready) aw_valid_q <= 1'b0;
            if (bus_rsp.w_ready) w_valid_q <= 1'b0;
            case (state_q)
                st_idle: begin
                    if (req_hs && bad_align) begin
                        state_q <= st_resp;     // refused, no bus access
                        err_q   <= 1'b1;
                    end else if (req_hs) begin
                        state_q    <= st_addr;
                        err_q      <= 1'b0;
                        ar_valid_q <= !req.store;
                        aw_valid_q <= req.store;
                        w_valid_q  <= req.store;
                    end
                end
                st_addr: begin
                    if (!addr_pend) state_q <= st_wait;
                end
                st_wait: begin
                    if (r_hs) begin
                        err_q   <= (bus_rsp.r_resp != resp_okay);
                        state_q <= st_resp;
                    end else if (b_hs) begin
                        err_q   <= (bus_rsp.b_resp != resp_okay);
                        state_q <= st_resp;
                    end
                end
                default: begin
                    if (rsp_ready) state_q <= st_idle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (req_hs) begin
            req_q   <= req;
            rword_q <= '0;      // stores report zero data
        end
        if (r_hs) rword_q <= bus_rsp.r_data;
    end

    assign rshift = rword_q >> shamt;

    always_comb begin
        rsp.err = err_q;
        case (req_q.size)
            size_byte: rsp.rdata = {{24{req_q.sign & rshift[7]}}, rshift[7:0]};
            size_half: rsp.rdata = {{16{req_q.sign & rshift[15]}}, rshift[15:0]};
            default:   rsp.rdata = rshift;
        endcase
    end

    a_one_in_flight: assert property (@(posedge clk) disable iff (!rst_n)
        req_hs |=> !req_ready until (rsp_valid && rsp_ready));

    a_strb_nonzero: assert property (@(posedge clk) disable iff (!rst_n)
        bus_req.w_valid |-> bus_req.w_strb != 4'b0000);

endmodule

`default_nettype wire

//--- lsu_pkg.sv
`default_nettype none

package lsu_pkg;

    typedef enum logic [1:0] {
        size_byte = 2'd1,
        size_half = 2'd2,
        size_word = 2'd3
    } lsu_size_e;

    typedef struct packed {
        logic        store;
        logic        sign;
        lsu_size_e   size;
        logic [31:0] addr;
        logic [31:0] wdata;     // right-aligned
    } lsu_req_t;

    typedef struct packed {
        logic [31:0] rdata;
        logic        err;
    } lsu_rsp_t;

    typedef struct packed {
        logic        aw_valid;
        logic [31:0] aw_addr;
        logic [2:0]  aw_prot;
        logic        w_valid;
        logic [31:0] w_data;
        logic [3:0]  w_strb;
        logic        b_ready;
        logic        ar_valid;
        logic [31:0] ar_addr;
        logic [2:0]  ar_prot;
        logic        r_ready;
    } axil_req_t;

    typedef struct packed {
        logic        aw_ready;
        logic        w_ready;
        logic        b_valid;
        logic [1:0]  b_resp;
        logic        ar_ready;
        logic        r_valid;
        logic [31:0] r_data;
        logic [1:0]  r_resp;
    } axil_rsp_t;

    localparam logic [1:0] resp_okay   = 2'b00;
    localparam logic [1:0] resp_slverr = 2'b10;
    localparam logic [1:0] resp_decerr = 2'b11;

endpackage

`default_nettype wire

//--- lsu_sys.f
+incdir+.
lsu_pkg.sv
lsu.sv
lsu_xbar.sv
sram_axil.sv
clint_axil.sv
lsu_sys.sv
tb_lsu_sys.sv

//--- lsu_sys.sv
`timescale 1ns/1ns
`default_nettype none

module lsu_sys
    import lsu_pkg::*;
#(
    parameter logic [31:0] sram_base       = 32'h8000_0000,
    parameter int          sram_words_log2 = 10,
    parameter logic [31:0] clint_base      = 32'h0200_0000,
    parameter logic [31:0] clint_size      = 32'h0001_0000
) (
    input  wire           clk,
    input  wire           rst_n,
    input  wire           req_valid,
    output logic          req_ready,
    input  wire lsu_req_t req,
    output logic          rsp_valid,
    input  wire           rsp_ready,
    output lsu_rsp_t      rsp
);

    axil_req_t lsu_bus_req, sram_req, clint_req;
    axil_rsp_t lsu_bus_rsp, sram_rsp, clint_rsp;

    lsu u_lsu (
        .clk       (clk),
        .rst_n     (rst_n),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .req       (req),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready),
        .rsp       (rsp),
        .bus_req   (lsu_bus_req),
        .bus_rsp   (lsu_bus_rsp)
    );

    lsu_xbar #(
        .sram_base       (sram_base),
        .sram_words_log2 (sram_words_log2),
        .clint_base      (clint_base),
        .clint_size      (clint_size)
    ) u_xbar (
        .clk       (clk),
        .rst_n     (rst_n),
        .mst_req   (lsu_bus_req),
        .mst_rsp   (lsu_bus_rsp),
        .sram_req  (sram_req),
        .sram_rsp  (sram_rsp),
        .clint_req (clint_req),
        .clint_rsp (clint_rsp)
    );

    sram_axil #(
        .words_log2 (sram_words_log2)
    ) u_sram (
        .clk     (clk),
        .rst_n   (rst_n),
        .bus_req (sram_req),
        .bus_rsp (sram_rsp)
    );

    clint_axil u_clint (
        .clk     (clk),
        .rst_n   (rst_n),
        .bus_req (clint_req),
        .bus_rsp (clint_rsp)
    );

endmodule

`default_nettype wire

//--- lsu_xbar.sv
`timescale 1ns/1ns
`default_nettype none

module lsu_xbar
    import lsu_pkg::*;
#(
    parameter logic [31:0] sram_base       = 32'h8000_0000,
    parameter int          sram_words_log2 = 10,
    parameter logic [31:0] clint_base      = 32'h0200_0000,
    parameter logic [31:0] clint_size      = 32'h0001_0000
) (
    input  wire            clk,
    input  wire            rst_n,
    input  wire axil_req_t mst_req,
    output axil_rsp_t      mst_rsp,
    output axil_req_t      sram_req,
    input  wire axil_rsp_t sram_rsp,
    output axil_req_t      clint_req,
    input  wire axil_rsp_t clint_rsp
);

    typedef enum logic [1:0] {tgt_sram, tgt_clint, tgt_none} tgt_e;

    localparam logic [32:0] sram_bytes = 33'd4 << sram_words_log2;

    tgt_e      aw_tgt, ar_tgt, w_tgt, wr_tgt_q, rd_tgt_q;
    logic      wr_busy_q, rd_busy_q;
    logic      dec_w_q, dec_b_q, dec_r_q;
    logic      w_fwd, aw_hs, w_hs, b_hs, ar_hs, r_hs;
    logic      dec_aw_hs, dec_w_hs, dec_aw_got;
    axil_rsp_t dec_rsp, aw_sel, w_sel, b_sel, ar_sel, r_sel;

    function automatic tgt_e decode(logic [31:0] addr);
        if ({1'b0, addr - sram_base} < sram_bytes) return tgt_sram;
        if ((addr - clint_base) < clint_size) return tgt_clint;
        return tgt_none;
    endfunction

    function automatic axil_rsp_t pick(tgt_e t);
        case (t)
            tgt_sram:  return sram_rsp;
            tgt_clint: return clint_rsp;
            default:   return dec_rsp;
        endcase
    endfunction

    function automatic axil_req_t route(tgt_e t);
        axil_req_t r;
        r          = mst_req;
        r.aw_valid = mst_req.aw_valid && !wr_busy_q && aw_tgt == t;
        r.w_valid  = w_fwd && w_tgt == t;
        r.b_ready  = mst_req.b_ready && wr_busy_q && wr_tgt_q == t;
        r.ar_valid = mst_req.ar_valid && !rd_busy_q && ar_tgt == t;
        r.r_ready  = mst_req.r_ready && rd_busy_q && rd_tgt_q == t;
        return r;
    endfunction

    assign aw_tgt = decode(mst_req.aw_addr);
    assign ar_tgt = decode(mst_req.ar_addr);
    assign w_tgt  = wr_busy_q ? wr_tgt_q : aw_tgt;    // W may precede AW
    assign w_fwd  = mst_req.w_valid && (wr_busy_q || mst_req.aw_valid);

    always_comb begin
        dec_rsp          = '0;
        dec_rsp.aw_ready = 1'b1;
        dec_rsp.w_ready  = !dec_w_q && !dec_b_q;
        dec_rsp.b_valid  = dec_b_q;
        dec_rsp.b_resp   = resp_decerr;
        dec_rsp.ar_ready = 1'b1;
        dec_rsp.r_valid  = dec_r_q;
        dec_rsp.r_resp   = resp_decerr;
        sram_req         = route(tgt_sram);
        clint_req        = route(tgt_clint);
        aw_sel           = pick(aw_tgt);
        w_sel            = pick(w_tgt);
        b_sel            = pick(wr_tgt_q);
        ar_sel           = pick(ar_tgt);
        r_sel            = pick(rd_tgt_q);
        mst_rsp          = r_sel;       // r_data and r_resp
        mst_rsp.aw_ready = aw_sel.aw_ready && !wr_busy_q;
        mst_rsp.w_ready  = w_sel.w_ready && w_fwd;
        mst_rsp.b_valid  = b_sel.b_valid && wr_busy_q;
        mst_rsp.b_resp   = b_sel.b_resp;
        mst_rsp.ar_ready = ar_sel.ar_ready && !rd_busy_q;
        mst_rsp.r_valid  = r_sel.r_valid && rd_busy_q;
    end

    assign aw_hs      = mst_req.aw_valid && mst_rsp.aw_ready;
    assign w_hs       = mst_req.w_valid && mst_rsp.w_ready;
    assign b_hs       = mst_rsp.b_valid && mst_req.b_ready;
    assign ar_hs      = mst_req.ar_valid && mst_rsp.ar_ready;
    assign r_hs       = mst_rsp.r_valid && mst_req.r_ready;
    assign dec_aw_hs  = aw_hs && aw_tgt == tgt_none;
    assign dec_w_hs   = w_hs && w_tgt == tgt_none;
    assign dec_aw_got = (wr_busy_q && wr_tgt_q == tgt_none) || dec_aw_hs;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_busy_q <= 1'b0;
            rd_busy_q <= 1'b0;
            wr_tgt_q  <= tgt_none;
            rd_tgt_q  <= tgt_none;
            dec_w_q   <= 1'b0;
            dec_b_q   <= 1'b0;
            dec_r_q   <= 1'b0;
        end else begin
            if (aw_hs) begin
                wr_busy_q <= 1'b1;
                wr_tgt_q  <= aw_tgt;
            end else if (b_hs) begin
                wr_busy_q <= 1'b0;
            end
            if (ar_hs) begin
                rd_busy_q <= 1'b1;
                rd_tgt_q  <= ar_tgt;
            end else if (r_hs) begin
                rd_busy_q <= 1'b0;
            end
            if (dec_w_hs) dec_w_q <= 1'b1;
            if (dec_aw_got && (dec_w_q || dec_w_hs)) begin
                dec_b_q <= 1'b1;    // both halves taken
                dec_w_q <= 1'b0;
            end else if (b_hs) begin
                dec_b_q <= 1'b0;
            end
            if (ar_hs && ar_tgt == tgt_none) dec_r_q <= 1'b1;
            else if (r_hs) dec_r_q <= 1'b0;
        end
    end

    a_ar_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0({sram_req.ar_valid, clint_req.ar_valid}));

endmodule

`default_nettype wire

//--- sram_axil.sv
`timescale 1ns/1ns
`default_nettype none

module sram_axil
    import lsu_pkg::*;
#(
    parameter int words_log2 = 10
) (
    input  wire            clk,
    input  wire            rst_n,
    input  wire axil_req_t bus_req,
    output axil_rsp_t      bus_rsp
);

    logic [31:0]           mem [2**words_log2];
    logic                  r_valid_q;
    logic [31:0]           r_data_q;
    logic                  aw_got_q;
    logic                  w_got_q;
    logic                  b_valid_q;
    logic [words_log2-1:0] aw_idx_q;
    logic [31:0]           w_data_q;
    logic [3:0]            w_strb_q;
    logic                  ar_hs, aw_hs, w_hs, wr_fire;
    logic [words_log2-1:0] wr_idx;
    logic [31:0]           wr_data;
    logic [3:0]            wr_strb;

    always_comb begin
        bus_rsp          = '0;
        bus_rsp.aw_ready = !aw_got_q && !b_valid_q;
        bus_rsp.w_ready  = !w_got_q && !b_valid_q;
        bus_rsp.b_valid  = b_valid_q;
        bus_rsp.b_resp   = resp_okay;
        bus_rsp.ar_ready = !r_valid_q;      // one read slot
        bus_rsp.r_valid  = r_valid_q;
        bus_rsp.r_data   = r_data_q;
        bus_rsp.r_resp   = resp_okay;
    end

    assign ar_hs   = bus_req.ar_valid && bus_rsp.ar_ready;
    assign aw_hs   = bus_req.aw_valid && bus_rsp.aw_ready;
    assign w_hs    = bus_req.w_valid && bus_rsp.w_ready;
    assign wr_fire = (aw_got_q || aw_hs) && (w_got_q || w_hs);

    // latched half or the one arriving now
    assign wr_idx  = aw_got_q ? aw_idx_q : bus_req.aw_addr[words_log2+1:2];
    assign wr_data = w_got_q ? w_data_q : bus_req.w_data;
    assign wr_strb = w_got_q ? w_strb_q : bus_req.w_strb;

    always_ff @(posedge clk) begin
        if (wr_fire) begin
            for (int i = 0; i < 4; i++) begin
                if (wr_strb[i]) mem[wr_idx][8*i +: 8] <= wr_data[8*i +: 8];
            end
        end
        if (ar_hs) r_data_q <= mem[bus_req.ar_addr[words_log2+1:2]];
        if (aw_hs) aw_idx_q <= bus_req.aw_addr[words_log2+1:2];
        if (w_hs) begin
            w_data_q <= bus_req.w_data;
            w_strb_q <= bus_req.w_strb;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            r_valid_q <= 1'b0;
            aw_got_q  <= 1'b0;
            w_got_q   <= 1'b0;
            b_valid_q <= 1'b0;
        end else begin
            if (ar_hs) r_valid_q <= 1'b1;
            else if (bus_req.r_ready) r_valid_q <= 1'b0;
            if (wr_fire) begin
                aw_got_q  <= 1'b0;
                w_got_q   <= 1'b0;
                b_valid_q <= 1'b1;
            end else begin
                if (aw_hs) aw_got_q <= 1'b1;
                if (w_hs) w_got_q <= 1'b1;
                if (bus_req.b_ready) b_valid_q <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

//--- tb_lsu_tasks.svh
task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    if (act !== exp) begin
        errors++;
        $display("Fail %s: expected %h, got %h", name, exp, act);
    end
endtask

task automatic fail_note(input string msg);
    errors++;
    $display("%s", msg);
endtask

function automatic int width_bytes(input lsu_size_e sz);
    case (sz)
        size_byte: return 1;
        size_half: return 2;
        default:   return 4;
    endcase
endfunction

function automatic void model_store(input logic [31:0] addr, input lsu_size_e sz,
                                    input logic [31:0] wdata);
    logic [11:0] idx;
    idx = addr[11:0];   // base is 4 KiB aligned
    for (int i = 0; i < width_bytes(sz); i++) begin
        model_mem[idx] = wdata[8*i +: 8];
        idx = idx + 12'd1;
    end
endfunction

function automatic logic [31:0] model_load(input logic [31:0] addr, input lsu_size_e sz,
                                           input logic sg);
    logic [11:0] idx;
    logic [31:0] v;
    v   = '0;
    idx = addr[11:0];
    for (int i = 0; i < width_bytes(sz); i++) begin
        v[8*i +: 8] = model_mem[idx];
        idx = idx + 12'd1;
    end
    if (sg && sz == size_byte && v[7]) v[31:8] = '1;
    if (sg && sz == size_half && v[15]) v[31:16] = '1;
    return v;
endfunction

// drive one request and return once it has been taken
task automatic send_req(input logic st, input logic sg, input lsu_size_e sz,
                        input logic [31:0] addr, input logic [31:0] wdata);
    req_valid = 1'b1;
    req.store = st;
    req.sign  = sg;
    req.size  = sz;
    req.addr  = addr;
    req.wdata = wdata;
    @(negedge clk);
    while (!req_ready) @(negedge clk);
    @(posedge clk);
    #2;
    req_valid = 1'b0;
endtask

task automatic issue_req(input logic st, input logic sg, input lsu_size_e sz,
                         input logic [31:0] addr, input logic [31:0] wdata,
                         output lsu_rsp_t r, output int lat);
    send_req(st, sg, sz, addr, wdata);
    lat = 1;
    @(negedge clk);
    while (!rsp_valid) begin
        @(negedge clk);
        lat++;
    end
    r = rsp;
    @(posedge clk);     // taken here with rsp_ready high
    #2;
endtask

task automatic sram_access(input logic st, input logic sg, input lsu_size_e sz,
                           input logic [31:0] addr, input logic [31:0] wdata);
    lsu_rsp_t    r;
    int          lat;
    logic [31:0] exp;
    exp = model_load(addr, sz, sg);
    issue_req(st, sg, sz, addr, wdata, r, lat);
    if (st) model_store(addr, sz, wdata);
    else check_val("rsp.rdata", exp, r.rdata);
    check_val("rsp.err", 32'd0, {31'd0, r.err});
    checks++;
    if (lat > 3) fail_note($sformatf("SRAM access at %h took %0d cycles", addr, lat));
endtask

task automatic expect_err(input logic st, input lsu_size_e sz, input logic [31:0] addr,
                          input int limit);
    lsu_rsp_t r;
    int       lat;
    issue_req(st, 1'b0, sz, addr, 32'hffff_ffff, r, lat);
    check_val("rsp.err", 32'd1, {31'd0, r.err});
    checks++;
    if (lat > limit) fail_note($sformatf("error response at %h took %0d cycles", addr, lat));
endtask

task automatic word_round_trip();
    logic [31:0] a;
    for (int i = 0; i < 9; i++) begin
        a = sram_base + 32'h1c4 * i;
        sram_access(1'b1, 1'b0, size_word, a, a ^ 32'h3c5a_96e1);
    end
    for (int i = 0; i < 9; i++) begin
        sram_access(1'b0, 1'b0, size_word, sram_base + 32'h1c4 * i, 32'd0);
    end
endtask

task automatic sub_word_access();
    logic [31:0] a;
    a = sram_base + 32'h100;
    for (int off = 0; off < 4; off++) begin
        sram_access(1'b1, 1'b0, size_word, a, 32'h7f80_19e6);
        sram_access(1'b1, 1'b0, size_byte, a + off, 32'hcafe_ba80 + off * 32'h11);
        sram_access(1'b0, 1'b0, size_word, a, 32'd0);  // neighbours intact
        sram_access(1'b0, 1'b1, size_byte, a + off, 32'd0);
        sram_access(1'b0, 1'b0, size_byte, a + off, 32'd0);
        sram_access(1'b0, 1'b1, size_byte, a + ((off + 1) % 4), 32'd0);
    end
    for (int off = 0; off < 4; off += 2) begin
        sram_access(1'b1, 1'b0, size_word, a, 32'h1234_5678);
        sram_access(1'b1, 1'b0, size_half, a + off, 32'hfeed_9abc + off);
        sram_access(1'b0, 1'b0, size_word, a, 32'd0);
        sram_access(1'b0, 1'b1, size_half, a + off, 32'd0);
        sram_access(1'b0, 1'b0, size_half, a + off, 32'd0);
        sram_access(1'b0, 1'b1, size_half, a + (2 - off), 32'd0);
    end
endtask

task automatic error_cases();
    logic [31:0] a;
    a = sram_base + 32'h200;
    sram_access(1'b1, 1'b0, size_word, a, 32'h0bad_f00d);
    expect_err(1'b1, size_half, a + 32'd1, 2);
    expect_err(1'b1, size_word, a + 32'd2, 2);
    expect_err(1'b0, size_half, a + 32'd3, 2);
    sram_access(1'b0, 1'b0, size_word, a, 32'd0);      // still the old word
    expect_err(1'b0, size_word, 32'h1000_0000, 3);
    expect_err(1'b1, size_word, 32'h1000_0004, 3);
endtask

task automatic timer_reads();
    lsu_rsp_t lo0;
    lsu_rsp_t lo1;
    lsu_rsp_t hi;
    int       lat;
    int       gap;
    gap = 20 + $urandom % 30;
    issue_req(1'b0, 1'b0, size_word, clint_base, 32'd0, lo0, lat);
    checks++;
    if (lo0.rdata > cycles - rst_cycle) fail_note("mtime ahead of the cycles since reset");
    repeat (gap) @(posedge clk);
    #2;
    issue_req(1'b0, 1'b0, size_word, clint_base, 32'd0, lo1, lat);
    checks++;
    if (lo1.rdata <= lo0.rdata || lo1.rdata - lo0.rdata < gap) begin
        errors++;
        $display("Fail mtime lo: first %h, second %h, gap %0d", lo0.rdata, lo1.rdata, gap);
    end
    issue_req(1'b0, 1'b0, size_word, clint_base + 32'd4, 32'd0, hi, lat);
    check_val("mtime hi", 32'd0, hi.rdata);     // upper word still zero in a short run
    check_val("rsp.err", 32'd0, {31'd0, hi.err});
    expect_err(1'b1, size_word, clint_base, 3);
endtask

task automatic back_pressure();
    lsu_rsp_t    held;
    int          hold;
    logic [31:0] a;
    a    = sram_base + 32'h180;
    hold = 1 + $urandom % 10;
    sram_access(1'b1, 1'b0, size_word, a, 32'h5ee1_ab1e);
    rsp_ready = 1'b0;
    send_req(1'b0, 1'b1, size_half, a + 32'd2, 32'd0);
    @(negedge clk);
    while (!rsp_valid) @(negedge clk);
    held = rsp;
    check_val("rsp.rdata", model_load(a + 32'd2, size_half, 1'b1), held.rdata);
    check_val("rsp.err", 32'd0, {31'd0, held.err});
    repeat (hold) begin
        @(negedge clk);
        checks++;
        if (rsp_valid !== 1'b1 || req_ready !== 1'b0) begin
            fail_note("response dropped while rsp_ready was low");
        end
        check_val("rsp.rdata", held.rdata, rsp.rdata);
        check_val("rsp.err", {31'd0, held.err}, {31'd0, rsp.err});
    end
    @(posedge clk);
    #2;
    rsp_ready = 1'b1;
    @(posedge clk);     // taken on this edge
    #2;
    @(negedge clk);
    checks++;
    if (rsp_valid !== 1'b0 || req_ready !== 1'b1) fail_note("response not taken exactly once");
    @(posedge clk);
    #2;
endtask

task automatic random_sequence();
    logic [31:0] a;
    logic [31:0] rnd;
    lsu_size_e   sz;
    for (int i = 0; i < 16; i++) begin
        a = sram_base + 32'h400 + 32'd4 * i;
        sram_access(1'b1, 1'b0, size_word, a, a ^ 32'ha5c3_0f1e);
    end
    for (int n = 0; n < 200; n++) begin
        rnd = $urandom;
        sz  = (rnd[3:2] == 2'd0) ? size_byte : (rnd[3:2] == 2'd1) ? size_half : size_word;
        a   = sram_base + 32'h400 + {26'd0, rnd[9:4]};
        if (sz == size_half) a[0] = 1'b0;
        if (sz == size_word) a[1:0] = 2'b00;
        sram_access(rnd[0], rnd[1], sz, a, $urandom);
    end
endtask

//--- tb_lsu_sys.sv
`timescale 1ns/1ns
`default_nettype none

module tb_lsu_sys
    import lsu_pkg::*;
();

    localparam logic [31:0] sram_base  = 32'h8000_0000;
    localparam logic [31:0] clint_base = 32'h0200_0000;
    localparam int          mem_bytes  = 4096;      // 2**10 words
    localparam int          max_cycles = 4000;

    logic       clk;
    logic       rst_n;
    logic       req_valid;
    logic       req_ready;
    lsu_req_t   req;
    logic       rsp_valid;
    logic       rsp_ready;
    lsu_rsp_t   rsp;
    logic [7:0] model_mem [mem_bytes];  // byte image of the SRAM
    int         errors;
    int         checks;
    int         cycles;
    int         rst_cycle;

    lsu_sys uut (
        .clk       (clk),
        .rst_n     (rst_n),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .req       (req),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready),
        .rsp       (rsp)
    );

    `include "tb_lsu_tasks.svh"

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= max_cycles) begin
            $display("timeout: run still busy after %0d cycles", cycles);
            $display("Done: errors found");
            $finish;
        end
    end

    initial begin
        void'($urandom(21));
        errors    = 0;
        checks    = 0;
        cycles    = 0;
        rst_n     = 1'b0;
        req_valid = 1'b0;
        req       = '0;
        rsp_ready = 1'b1;
        repeat (5) @(posedge clk);
        #2;
        rst_n     = 1'b1;
        rst_cycle = cycles;
        @(negedge clk);
        checks++;
        if (req_ready !== 1'b1 || rsp_valid !== 1'b0) begin
            fail_note("handshake outputs wrong after reset");
        end
        @(posedge clk);
        #2;

        word_round_trip();
        sub_word_access();
        error_cases();
        timer_reads();
        back_pressure();
        random_sequence();

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire
